// File: common/ndn_name_pkg.sv
// Name, length and hash definitions shared by the FIB, the PIT and the hash units
// Names are top-aligned, so a prefix of length L lives in bits 63 down to 64-L
// The hash rule assumes a hash width of at least 6 bits
package ndn_name_pkg;

    typedef logic [63:0] name_t;
    typedef logic [5:0]  name_len_t;

    parameter int HASH_W_DEFAULT = 10;

    // Clear every name bit below the prefix length
    function automatic name_t mask_name(name_t prefix, name_len_t len);
        return prefix & ~({64{1'b1}} >> len);
    endfunction

    // Fold the masked name into hash_w-bit chunks from bit 0, then mix in the length
    // Only the low hash_w bits of the result are meaningful
    function automatic name_t hash_name(name_t prefix, name_len_t len, int unsigned hash_w);
        name_t masked;
        name_t folded;
        masked = mask_name(prefix, len);
        folded = '0;
        for (int unsigned i = 0; i < 64; i++) begin
            folded[i % hash_w] = folded[i % hash_w] ^ masked[i];
        end
        folded[5:0] = folded[5:0] ^ len;
        return folded;
    endfunction

endpackage

// File: common/ndn_fwd_pkg.sv
// Payload and PIT sizing definitions for the forwarding core
// Payload length must fit the 16-bit byte counter
package ndn_fwd_pkg;

    // One payload byte on the data stream
    typedef logic [7:0] byte_t;

    // Counts bytes within one data packet
    typedef logic [15:0] byte_cnt_t;

    // Pending interest slots
    parameter int PIT_DEPTH_DEFAULT = 8;

    // Fixed payload size per satisfied data packet
    parameter int PAYLOAD_BYTES_DEFAULT = 16;

endpackage

// File: src/name_hash.sv
// Registered hash of a masked name prefix, one cycle from inputs to hash_out
// HASH_W must be at least 6 so the length mixes into the low bits
module name_hash #(
    parameter int HASH_W = ndn_name_pkg::HASH_W_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst,
    input  ndn_name_pkg::name_t     prefix,
    input  ndn_name_pkg::name_len_t len,
    output logic [HASH_W-1:0]       hash_out
);
    import ndn_name_pkg::*;

    name_t folded;

    // Mask, fold and length mix per the shared rule
    always_comb begin
        folded = hash_name(prefix, len, HASH_W);
    end

    // Hash is sampled every cycle
    // Callers hold the inputs for the cycle they care about
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash_out <= '0;
        end else begin
            hash_out <= folded[HASH_W-1:0];
        end
    end

endmodule

// File: fib/fib_table.sv
// FIB with one valid bit per (length, hash) pair, so hash collisions give false matches
// Learning takes a hash cycle and a write cycle; a learn during the write cycle is lost
// Lookup probes from the requested length down to 1, two cycles per probe
module fib_table #(
    parameter int HASH_W = ndn_name_pkg::HASH_W_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    learn_en,
    input  ndn_name_pkg::name_t     learn_prefix,
    input  ndn_name_pkg::name_len_t learn_len,
    input  logic                    lookup_start,
    input  ndn_name_pkg::name_t     lookup_prefix,
    input  ndn_name_pkg::name_len_t lookup_len,
    output logic                    lookup_busy,
    output logic                    fwd_valid,
    output ndn_name_pkg::name_t     fwd_prefix,
    output ndn_name_pkg::name_len_t fwd_len,
    output logic                    fwd_hit
);
    import ndn_name_pkg::*;

    localparam int ROW_BITS = 1 << HASH_W;

    typedef enum logic {L_IDLE, L_WRITE} learn_state_t;
    typedef enum logic [1:0] {S_IDLE, S_HASH, S_CHECK, S_DONE} search_state_t;

    // One row of valid bits per prefix length
    logic [ROW_BITS-1:0] valid_bits [64];

    learn_state_t        learn_state;
    name_len_t           learn_len_q;
    logic [HASH_W-1:0]   learn_hash;

    search_state_t       search_state;
    name_t               search_prefix;
    name_len_t           search_len;
    name_len_t           match_len;
    logic                match_hit;
    logic [HASH_W-1:0]   search_hash;
    logic                probe_set;

    // Separate hash units so learning runs alongside a lookup
    name_hash #(.HASH_W(HASH_W)) learn_hash_inst (
        .clk      (clk),
        .rst      (rst),
        .prefix   (learn_prefix),
        .len      (learn_len),
        .hash_out (learn_hash)
    );

    name_hash #(.HASH_W(HASH_W)) search_hash_inst (
        .clk      (clk),
        .rst      (rst),
        .prefix   (search_prefix),
        .len      (search_len),
        .hash_out (search_hash)
    );

    // Learn FSM, hash lands in the cycle after learn_en
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            learn_state <= L_IDLE;
            learn_len_q <= '0;
            for (int r = 0; r < 64; r++) begin
                valid_bits[r] <= '0;
            end
        end else begin
            case (learn_state)
                L_IDLE: begin
                    if (learn_en) begin
                        learn_len_q <= learn_len;
                        learn_state <= L_WRITE;
                    end
                end
                L_WRITE: begin
                    valid_bits[learn_len_q][learn_hash] <= 1'b1;
                    learn_state <= L_IDLE;
                end
            endcase
        end
    end

    // Probe read sees the old bit when a write lands in the same cycle
    assign probe_set = valid_bits[search_len][search_hash];

    // Search FSM, one hash cycle then one check cycle per length
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            search_state <= S_IDLE;
            search_len   <= '0;
            match_len    <= '0;
            match_hit    <= 1'b0;
        end else begin
            case (search_state)
                S_IDLE: begin
                    if (lookup_start) begin
                        search_len   <= lookup_len;
                        match_len    <= '0;
                        match_hit    <= 1'b0;
                        // Zero length has nothing to probe
                        search_state <= (lookup_len == '0) ? S_DONE : S_HASH;
                    end
                end
                S_HASH: begin
                    search_state <= S_CHECK;
                end
                S_CHECK: begin
                    if (probe_set) begin
                        match_len    <= search_len;
                        match_hit    <= 1'b1;
                        search_state <= S_DONE;
                    end else if (search_len == name_len_t'(1)) begin
                        search_state <= S_DONE;
                    end else begin
                        search_len   <= search_len - name_len_t'(1);
                        search_state <= S_HASH;
                    end
                end
                default: begin
                    search_state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (search_state == S_IDLE && lookup_start) begin
            search_prefix <= lookup_prefix;
        end
    end

    assign lookup_busy = (search_state != S_IDLE);
    assign fwd_valid   = (search_state == S_DONE);
    assign fwd_prefix  = search_prefix;
    assign fwd_len     = match_len;
    assign fwd_hit     = match_hit;

endmodule

// File: pit/pit_table.sv
// Fully associative Pending Interest Table with exact match on masked name and length
// Duplicates aggregate into one entry; inserts into a full table are dropped
// Query and insert of the same name in one cycle is not supported
module pit_table #(
    parameter int PIT_DEPTH = ndn_fwd_pkg::PIT_DEPTH_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ins_en,
    input  ndn_name_pkg::name_t     ins_prefix,
    input  ndn_name_pkg::name_len_t ins_len,
    input  logic                    q_en,
    input  ndn_name_pkg::name_t     q_prefix,
    input  ndn_name_pkg::name_len_t q_len,
    output logic                    q_hit
);
    import ndn_name_pkg::*;

    localparam int IDX_W = (PIT_DEPTH > 1) ? $clog2(PIT_DEPTH) : 1;

    logic [PIT_DEPTH-1:0] entry_valid;
    name_t                entry_name [PIT_DEPTH];
    name_len_t            entry_len  [PIT_DEPTH];

    name_t                ins_masked;
    name_t                q_masked;
    logic [PIT_DEPTH-1:0] ins_match;
    logic [PIT_DEPTH-1:0] q_match;
    logic [IDX_W-1:0]     free_idx;
    logic                 ins_dup;
    logic                 tbl_full;
    logic                 do_insert;

    // Compare both names against every entry at once
    always_comb begin
        ins_masked = mask_name(ins_prefix, ins_len);
        q_masked   = mask_name(q_prefix, q_len);
        for (int i = 0; i < PIT_DEPTH; i++) begin
            ins_match[i] = entry_valid[i] && (entry_name[i] == ins_masked)
                           && (entry_len[i] == ins_len);
            q_match[i]   = entry_valid[i] && (entry_name[i] == q_masked)
                           && (entry_len[i] == q_len);
        end
    end

    // Lowest free slot wins, scan runs top down
    always_comb begin
        free_idx = '0;
        for (int i = PIT_DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign ins_dup   = |ins_match;
    assign tbl_full  = &entry_valid;
    assign do_insert = ins_en && !ins_dup && !tbl_full;

    // Query hit clears its entry; insert sets the free slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_valid <= '0;
            q_hit       <= 1'b0;
        end else begin
            q_hit <= q_en && (|q_match);
            if (q_en) begin
                entry_valid <= entry_valid & ~q_match;
            end
            if (do_insert) begin
                entry_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_insert) begin
            entry_name[free_idx] <= ins_masked;
            entry_len[free_idx]  <= ins_len;
        end
    end

endmodule

// File: src/data_forwarder.sv
// Data packet sequencer: learn the name, ask the PIT, then stream or reject
// Source must supply a valid data_byte in every pay_req cycle; no output back-pressure
module data_forwarder #(
    parameter int PAYLOAD_BYTES = ndn_fwd_pkg::PAYLOAD_BYTES_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    data_valid,
    input  ndn_name_pkg::name_t     data_prefix,
    input  ndn_name_pkg::name_len_t data_len,
    output logic                    data_ready,
    input  ndn_fwd_pkg::byte_t      data_byte,
    output logic                    pay_req,
    output ndn_fwd_pkg::byte_t      out_byte,
    output logic                    out_valid,
    output logic                    data_reject,
    output logic                    learn_en,
    output ndn_name_pkg::name_t     learn_prefix,
    output ndn_name_pkg::name_len_t learn_len,
    output logic                    pit_q_en,
    output ndn_name_pkg::name_t     pit_q_prefix,
    output ndn_name_pkg::name_len_t pit_q_len,
    input  logic                    pit_q_hit
);
    import ndn_fwd_pkg::*;

    typedef enum logic [1:0] {F_IDLE, F_WAIT_PIT, F_STREAM, F_REJECT} fwd_state_t;

    fwd_state_t state;
    byte_cnt_t  byte_cnt;
    logic       accept;

    assign data_ready = (state == F_IDLE);
    assign accept     = data_valid && data_ready;

    // Learn and PIT query both go out in the acceptance cycle
    assign learn_en     = accept;
    assign learn_prefix = data_prefix;
    assign learn_len    = data_len;
    assign pit_q_en     = accept;
    assign pit_q_prefix = data_prefix;
    assign pit_q_len    = data_len;

    assign pay_req     = (state == F_STREAM);
    assign data_reject = (state == F_REJECT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= F_IDLE;
            byte_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= pay_req;
            case (state)
                F_IDLE: begin
                    if (accept) begin
                        state <= F_WAIT_PIT;
                    end
                end
                F_WAIT_PIT: begin
                    byte_cnt <= '0;
                    state    <= pit_q_hit ? F_STREAM : F_REJECT;
                end
                F_STREAM: begin
                    byte_cnt <= byte_cnt + byte_cnt_t'(1);
                    // Last requested byte
                    if (byte_cnt == byte_cnt_t'(PAYLOAD_BYTES - 1)) begin
                        state <= F_IDLE;
                    end
                end
                default: begin
                    state <= F_IDLE;
                end
            endcase
        end
    end

    // Sampled byte shows up one cycle after its pay_req
    always_ff @(posedge clk) begin
        if (pay_req) begin
            out_byte <= data_byte;
        end
    end

endmodule

// File: src/ndn_router_top.sv
// NDN forwarding core: interests go to the PIT and the FIB, data goes through the forwarder
// One interest lookup at a time, int_ready drops while the FIB searches
module ndn_router_top #(
    parameter int HASH_W        = ndn_name_pkg::HASH_W_DEFAULT,
    parameter int PIT_DEPTH     = ndn_fwd_pkg::PIT_DEPTH_DEFAULT,
    parameter int PAYLOAD_BYTES = ndn_fwd_pkg::PAYLOAD_BYTES_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    int_valid,
    input  ndn_name_pkg::name_t     int_prefix,
    input  ndn_name_pkg::name_len_t int_len,
    output logic                    int_ready,
    output logic                    fwd_valid,
    output ndn_name_pkg::name_t     fwd_prefix,
    output ndn_name_pkg::name_len_t fwd_len,
    output logic                    fwd_hit,
    input  logic                    data_valid,
    input  ndn_name_pkg::name_t     data_prefix,
    input  ndn_name_pkg::name_len_t data_len,
    output logic                    data_ready,
    input  ndn_fwd_pkg::byte_t      data_byte,
    output logic                    pay_req,
    output ndn_fwd_pkg::byte_t      out_byte,
    output logic                    out_valid,
    output logic                    data_reject
);
    import ndn_name_pkg::*;

    logic      lookup_busy;
    logic      int_accept;
    logic      learn_en;
    name_t     learn_prefix;
    name_len_t learn_len;
    logic      pit_q_en;
    name_t     pit_q_prefix;
    name_len_t pit_q_len;
    logic      pit_q_hit;

    // Accepted interest feeds PIT insert and FIB lookup in the same cycle
    assign int_ready  = ~lookup_busy;
    assign int_accept = int_valid & ~lookup_busy;

    fib_table #(.HASH_W(HASH_W)) fib_table_inst (
        .clk           (clk),
        .rst           (rst),
        .learn_en      (learn_en),
        .learn_prefix  (learn_prefix),
        .learn_len     (learn_len),
        .lookup_start  (int_accept),
        .lookup_prefix (int_prefix),
        .lookup_len    (int_len),
        .lookup_busy   (lookup_busy),
        .fwd_valid     (fwd_valid),
        .fwd_prefix    (fwd_prefix),
        .fwd_len       (fwd_len),
        .fwd_hit       (fwd_hit)
    );

    pit_table #(.PIT_DEPTH(PIT_DEPTH)) pit_table_inst (
        .clk        (clk),
        .rst        (rst),
        .ins_en     (int_accept),
        .ins_prefix (int_prefix),
        .ins_len    (int_len),
        .q_en       (pit_q_en),
        .q_prefix   (pit_q_prefix),
        .q_len      (pit_q_len),
        .q_hit      (pit_q_hit)
    );

    data_forwarder #(.PAYLOAD_BYTES(PAYLOAD_BYTES)) data_forwarder_inst (
        .clk          (clk),
        .rst          (rst),
        .data_valid   (data_valid),
        .data_prefix  (data_prefix),
        .data_len     (data_len),
        .data_ready   (data_ready),
        .data_byte    (data_byte),
        .pay_req      (pay_req),
        .out_byte     (out_byte),
        .out_valid    (out_valid),
        .data_reject  (data_reject),
        .learn_en     (learn_en),
        .learn_prefix (learn_prefix),
        .learn_len    (learn_len),
        .pit_q_en     (pit_q_en),
        .pit_q_prefix (pit_q_prefix),
        .pit_q_len    (pit_q_len),
        .pit_q_hit    (pit_q_hit)
    );

endmodule

// File: verif/ndn_router_properties.sv
// Handshake and pulse rules for the forwarding core, bound onto ndn_router_top
// Rules are disabled while reset is high
module ndn_router_properties #(
    parameter int PAYLOAD_BYTES = ndn_fwd_pkg::PAYLOAD_BYTES_DEFAULT
) (
    input logic clk,
    input logic rst,
    input logic int_ready,
    input logic fwd_valid,
    input logic pay_req,
    input logic out_valid,
    input logic data_reject
);
    timeunit 1ns;
    timeprecision 100ps;

    // Lookup result and reject are single-cycle pulses
    fwd_pulse: assert property (@(posedge clk) disable iff (rst) fwd_valid |=> !fwd_valid)
        else $error("fwd_valid held for more than one cycle");
    reject_pulse: assert property (@(posedge clk) disable iff (rst) data_reject |=> !data_reject)
        else $error("data_reject held for more than one cycle");

    // A stream holds pay_req for exactly the payload length, then drops
    pay_len: assert property (@(posedge clk) disable iff (rst)
        $rose(pay_req) |-> pay_req [*PAYLOAD_BYTES] ##1 !pay_req)
        else $error("pay_req stream length differs from the payload size");

    // No new interest while a lookup result is pending
    ready_low: assert property (@(posedge clk) disable iff (rst) fwd_valid |-> !int_ready)
        else $error("int_ready high while fwd_valid is pending");

    // Output byte lags its request by exactly one cycle
    out_follow: assert property (@(posedge clk) disable iff (rst) pay_req |=> out_valid)
        else $error("out_valid missing one cycle after pay_req");
    out_quiet: assert property (@(posedge clk) disable iff (rst) !pay_req |=> !out_valid)
        else $error("out_valid without a pay_req in the cycle before");

endmodule

bind ndn_router_top ndn_router_properties #(
    .PAYLOAD_BYTES (PAYLOAD_BYTES)
) ndn_router_properties_inst (
    .clk         (clk),
    .rst         (rst),
    .int_ready   (int_ready),
    .fwd_valid   (fwd_valid),
    .pay_req     (pay_req),
    .out_valid   (out_valid),
    .data_reject (data_reject)
);

// File: verif/ndn_router_tb.sv
// Table-driven testbench for the forwarding core at the default parameters
// A FIB and PIT reference model gives every expected value; rows run one at a time
module ndn_router_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ndn_name_pkg::*;
    import ndn_fwd_pkg::*;

    localparam int HASH_W        = HASH_W_DEFAULT;
    localparam int PIT_DEPTH     = PIT_DEPTH_DEFAULT;
    localparam int PAYLOAD_BYTES = PAYLOAD_BYTES_DEFAULT;
    localparam int NUM_ROWS      = 29;
    // Worst row is a full 63-length search or one payload stream
    localparam int CYCLE_LIMIT   = 20 + NUM_ROWS * (2 * 63 + PAYLOAD_BYTES + 12);
    localparam bit OP_INT        = 1'b0;
    localparam bit OP_DATA       = 1'b1;

    logic      clk;
    logic      rst;
    logic      int_valid;
    name_t     int_prefix;
    name_len_t int_len;
    logic      int_ready;
    logic      fwd_valid;
    name_t     fwd_prefix;
    name_len_t fwd_len;
    logic      fwd_hit;
    logic      data_valid;
    name_t     data_prefix;
    name_len_t data_len;
    logic      data_ready;
    byte_t     data_byte;
    logic      pay_req;
    byte_t     out_byte;
    logic      out_valid;
    logic      data_reject;

    // Stimulus table: operation, name, length, expected fwd_len or PIT hit
    bit          row_op   [NUM_ROWS];
    name_t       row_name [NUM_ROWS];
    name_len_t   row_len  [NUM_ROWS];
    int          row_exp  [NUM_ROWS];
    int          row_cnt;

    // Reference model state
    bit          fib_bits [64][1 << HASH_W];
    bit          pit_v    [PIT_DEPTH];
    name_t       pit_n    [PIT_DEPTH];
    name_len_t   pit_l    [PIT_DEPTH];
    byte_t       exp_bytes [$];
    int          err_cnt;
    int          check_cnt;
    int          cycle_cnt;
    name_t       drv_name;

    ndn_router_top ndn_router_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Stall guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run stalled after %0d cycles", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(string sig, logic [63:0] got, logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got 0x%h expected 0x%h at %0t", sig, got, exp, $time);
        end
    endtask

    function automatic void add_row(bit op, name_t n, name_len_t l, int exp);
        row_op[row_cnt]   = op;
        row_name[row_cnt] = n;
        row_len[row_cnt]  = l;
        row_exp[row_cnt]  = exp;
        row_cnt++;
    endfunction

    // Keep the top l bits, bit 63 first
    function automatic name_t model_mask(name_t n, name_len_t l);
        name_t m;
        m = '0;
        for (int b = 0; b < l; b++) begin
            m[63 - b] = n[63 - b];
        end
        return m;
    endfunction

    // Fold in HASH_W chunks from bit 0, top chunk zero-padded, then add the length
    function automatic logic [HASH_W-1:0] model_hash(name_t n, name_len_t l);
        name_t             kept;
        logic [HASH_W-1:0] h;
        kept = model_mask(n, l);
        h = '0;
        for (int c = 0; c < 64; c += HASH_W) begin
            h = h ^ HASH_W'(kept >> c);
        end
        h[5:0] = h[5:0] ^ l;
        return h;
    endfunction

    // Longest set bit from l down to 1, zero on a miss
    function automatic int model_lookup(name_t n, name_len_t l);
        for (int k = l; k >= 1; k--) begin
            if (fib_bits[k][model_hash(n, name_len_t'(k))]) begin
                return k;
            end
        end
        return 0;
    endfunction

    // Aggregate a duplicate, else lowest free slot, else drop
    function automatic void model_pit_insert(name_t n, name_len_t l);
        for (int i = 0; i < PIT_DEPTH; i++) begin
            if (pit_v[i] && pit_n[i] == model_mask(n, l) && pit_l[i] == l) begin
                return;
            end
        end
        for (int i = 0; i < PIT_DEPTH; i++) begin
            if (!pit_v[i]) begin
                pit_v[i] = 1'b1;
                pit_n[i] = model_mask(n, l);
                pit_l[i] = l;
                return;
            end
        end
    endfunction

    // Exact match removes the entry
    function automatic bit model_pit_take(name_t n, name_len_t l);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < PIT_DEPTH; i++) begin
            if (pit_v[i] && pit_n[i] == model_mask(n, l) && pit_l[i] == l) begin
                pit_v[i] = 1'b0;
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic load_rows();
        add_row(OP_INT,  64'hA1B2_C3D4_E5F6_0718, 6'd20, 0);
        add_row(OP_DATA, 64'hA1B2_C3D4_E5F6_0718, 6'd16, 0);
        add_row(OP_DATA, 64'hA1B2_C3D4_E5F6_0718, 6'd32, 0);
        add_row(OP_INT,  64'hA1B2_C3D4_E5F6_0718, 6'd40, 32);
        add_row(OP_INT,  64'hA1B2_C3D4_E5F6_0718, 6'd24, 16);
        add_row(OP_INT,  64'hA1B2_C3D4_E5F6_0718, 6'd8,  0);
        // Satisfied, then the same data again
        add_row(OP_DATA, 64'hA1B2_C3D4_E5F6_0718, 6'd40, 1);
        add_row(OP_DATA, 64'hA1B2_C3D4_E5F6_0718, 6'd40, 0);
        add_row(OP_DATA, 64'hA1B2_C3D4_E5F6_0718, 6'd20, 1);
        add_row(OP_DATA, 64'hA1B2_C3D4_E5F6_0718, 6'd24, 1);
        add_row(OP_DATA, 64'hA1B2_C3D4_E5F6_0718, 6'd8,  1);
        // Unrequested data still teaches the FIB
        add_row(OP_DATA, 64'h5E5E_7A7A_0F0F_9C9C, 6'd48, 0);
        add_row(OP_INT,  64'h5E5E_7A7A_0F0F_9C9C, 6'd56, 48);
        add_row(OP_DATA, 64'h5E5E_7A7A_0F0F_9C9C, 6'd56, 1);
        // Two interests aggregate into one entry
        add_row(OP_INT,  64'hA150_0000_0000_0000, 6'd12, 8);
        add_row(OP_INT,  64'hA150_0000_0000_0000, 6'd12, 8);
        add_row(OP_DATA, 64'hA150_0000_0000_0000, 6'd12, 1);
        add_row(OP_DATA, 64'hA150_0000_0000_0000, 6'd12, 0);
        // Nine distinct names share the learned 24-bit route, the ninth finds the PIT full
        for (int k = 0; k < 9; k++) begin
            add_row(OP_INT, 64'hA1B2_C300_0000_0000 | (name_t'(k) << 34), 6'd30, 24);
        end
        add_row(OP_DATA, 64'hA1B2_C300_0000_0000 | (name_t'(8) << 34), 6'd30, 0);
        add_row(OP_DATA, 64'hA1B2_C300_0000_0000, 6'd30, 1);
    endtask

    task automatic run_interest(int r, name_t n);
        int exp_len;
        exp_len = model_lookup(n, row_len[r]);
        model_pit_insert(n, row_len[r]);
        if (exp_len != row_exp[r]) begin
            err_cnt++;
            $display("Row %0d: reference model disagrees with the table", r);
        end
        int_valid  <= 1'b1;
        int_prefix <= n;
        int_len    <= row_len[r];
        @(posedge clk);
        while (!int_ready) @(posedge clk);
        int_valid <= 1'b0;
        @(posedge clk);
        while (!fwd_valid) @(posedge clk);
        check_value("fwd_hit", fwd_hit, exp_len != 0);
        check_value("fwd_len", fwd_len, exp_len);
        check_value("fwd_prefix", fwd_prefix, n);
    endtask

    task automatic run_data(int r, name_t n);
        bit exp_hit;
        int rej_cnt;
        int out_cnt;
        fib_bits[row_len[r]][model_hash(n, row_len[r])] = 1'b1;
        exp_hit = model_pit_take(n, row_len[r]);
        if (exp_hit != row_exp[r]) begin
            err_cnt++;
            $display("Row %0d: reference model disagrees with the table", r);
        end
        rej_cnt = 0;
        out_cnt = 0;
        data_valid  <= 1'b1;
        data_prefix <= n;
        data_len    <= row_len[r];
        @(posedge clk);
        while (!data_ready) @(posedge clk);
        data_valid <= 1'b0;
        // Byte on data_byte now is the one sampled at this edge
        do begin
            @(posedge clk);
            if (pay_req) begin
                exp_bytes.push_back(data_byte);
            end
            data_byte <= byte_t'($urandom);
            if (out_valid) begin
                out_cnt++;
                if (exp_bytes.size() == 0) begin
                    check_value("out_valid", 1, 0);
                end else begin
                    check_value("out_byte", out_byte, exp_bytes.pop_front());
                end
            end
            if (data_reject) begin
                rej_cnt++;
            end
        end while (!data_ready);
        check_value("data_reject_pulses", rej_cnt, !exp_hit);
        check_value("out_valid_cycles", out_cnt, exp_hit ? PAYLOAD_BYTES : 0);
    endtask

    initial begin
        void'($urandom(32'hda87_e142));
        rst         = 1'b1;
        int_valid   = 1'b0;
        int_prefix  = '0;
        int_len     = '0;
        data_valid  = 1'b0;
        data_prefix = '0;
        data_len    = '0;
        data_byte   = '0;
        load_rows();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("int_ready", int_ready, 1);
        check_value("data_ready", data_ready, 1);
        check_value("fwd_valid", fwd_valid, 0);
        check_value("pay_req", pay_req, 0);
        check_value("out_valid", out_valid, 0);
        check_value("data_reject", data_reject, 0);
        for (int r = 0; r < row_cnt; r++) begin
            // Random bits below the prefix length must not matter
            drv_name = model_mask(row_name[r], row_len[r])
                       | ({$urandom, $urandom} & ~model_mask({64{1'b1}}, row_len[r]));
            if (row_op[r] == OP_DATA) begin
                run_data(r, drv_name);
            end else begin
                run_interest(r, drv_name);
            end
        end
        repeat (2) @(posedge clk);
        $display("Rows: %0d, checks: %0d, errors: %0d", row_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
common/ndn_name_pkg.sv
common/ndn_fwd_pkg.sv
src/name_hash.sv
fib/fib_table.sv
pit/pit_table.sv
src/data_forwarder.sv
src/ndn_router_top.sv
verif/ndn_router_properties.sv
verif/ndn_router_tb.sv
